// File: files.f
verilog/floo_pkg.sv
verilog/floo_flit_if.sv
verilog/floo_route_xymask.sv
verilog/floo_route_select.sv
verilog/floo_route_unit.sv
tb/floo_route_assert.sv
tb/floo_route_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the route unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module floo_route_tb \
  -f files.f \
  --Mdir "$BUILD_DIR" -o floo_route_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/floo_route_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb/floo_route_assert.sv
/*
 * floo route select assertions
 * one-hot route, route held while locked, lock clear in and after reset
 */

`timescale 1ns/1ps

module floo_route_assert (
  input logic                           clk_i,
  input logic                           arst_n_i,
  input logic                           locked_i,
  input logic [floo_pkg::NumRoutes-1:0] route_sel_i,
  input floo_pkg::route_dir_e           route_sel_id_i
);

  // exactly one direction at any time out of reset
  route_onehot: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $onehot(route_sel_i)
  ) else $error("route select is not one-hot");

  // body and tail flits see the head's route
  route_held: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
      locked_i |-> ($stable(route_sel_i) && $stable(route_sel_id_i))
  ) else $error("route changed while the packet lock is set");

  lock_in_reset: assert property (
    @(posedge clk_i) !arst_n_i |-> !locked_i
  ) else $error("packet lock set during reset");

  // first edge after release still sees a clear lock
  lock_after_reset: assert property (
    @(posedge clk_i) $rose(arst_n_i) |-> !locked_i
  ) else $error("packet lock set after reset release");

endmodule

bind floo_route_select floo_route_assert u_route_assert (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .locked_i       (locked_q),
  .route_sel_i    (route_sel_o),
  .route_sel_id_i (route_sel_id_o)
);

// File: tb/floo_route_tb.sv
/*
 * floo route unit testbench
 * LFSR packets with idle gaps and random back-pressure, checked against
 * a model of XY routing and packet lock, plus a reset in mid-packet
 */

`timescale 1ns/1ps

module floo_route_tb;
  import floo_pkg::*;

  localparam int NumPhases     = 3;
  localparam int PktsPerPhase  = 40;
  // cycles a flit may wait for its ready
  localparam int AcceptTimeout = 20;
  // after this many tries the selected ready is forced high
  localparam int ForceReady    = 6;

  logic                    clk_i;
  logic                    arst_n_i;
  xy_id_t                  xy_id_i;
  logic                    in_valid_i;
  logic [CoordWidth-1:0]   in_dst_x_i;
  logic [CoordWidth-1:0]   in_dst_y_i;
  logic                    in_last_i;
  logic [PayloadWidth-1:0] in_payload_i;
  logic                    in_ready_o;
  logic [NumRoutes-1:0]    out_valid_o;
  logic [NumRoutes-1:0]    out_ready_i;
  logic [CoordWidth-1:0]   out_dst_x_o;
  logic [CoordWidth-1:0]   out_dst_y_o;
  logic                    out_last_o;
  logic [PayloadWidth-1:0] out_payload_o;
  route_dir_e              out_route_id_o;

  // LFSR state and run bookkeeping
  logic [31:0] lfsr_q;
  logic [31:0] rnd;
  int unsigned errors;
  int unsigned checks;
  bit          aborted;

  // reference lock state
  bit          model_locked;
  route_dir_e  model_dir;

  floo_route_unit u_dut (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .xy_id_i        (xy_id_i),
    .in_valid_i     (in_valid_i),
    .in_dst_x_i     (in_dst_x_i),
    .in_dst_y_i     (in_dst_y_i),
    .in_last_i      (in_last_i),
    .in_payload_i   (in_payload_i),
    .in_ready_o     (in_ready_o),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .out_dst_x_o    (out_dst_x_o),
    .out_dst_y_o    (out_dst_y_o),
    .out_last_o     (out_last_o),
    .out_payload_o  (out_payload_o),
    .out_route_id_o (out_route_id_o)
  );

  // clock starts high so the first falling edge comes before any rising one
  initial begin
    clk_i = 1'b1;
    forever #10 clk_i = ~clk_i;
  end

  // fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
  function automatic logic [31:0] draw(int nbits);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // reference XY rule resolves x first and then y and ejects on a match
  function automatic route_dir_e xy_route(xy_id_t dst, xy_id_t here);
    if (dst.x != here.x) begin
      return (dst.x < here.x) ? West : East;
    end
    if (dst.y != here.y) begin
      return (dst.y < here.y) ? South : North;
    end
    return Eject;
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // every output against the expected route and the flit being driven
  task automatic check_outputs(string name, route_dir_e dir);
    logic [NumRoutes-1:0] onehot;
    onehot      = '0;
    onehot[dir] = 1'b1;
    check_value({name, " valid"}, 32'(onehot), 32'(out_valid_o));
    check_value({name, " route id"}, 32'(dir), 32'(out_route_id_o));
    // only the selected direction's ready counts
    check_value({name, " ready"}, 32'(out_ready_i[dir]), 32'(in_ready_o));
    check_value({name, " dst x"}, 32'(in_dst_x_i), 32'(out_dst_x_o));
    check_value({name, " dst y"}, 32'(in_dst_y_i), 32'(out_dst_y_o));
    check_value({name, " last"}, 32'(in_last_i), 32'(out_last_o));
    check_value({name, " payload"}, 32'(in_payload_i), 32'(out_payload_o));
  endtask

  task automatic send_flit(string name, xy_id_t dst, logic last);
    route_dir_e  dir;
    logic [31:0] r;
    int unsigned tries;
    bit          accepted;
    @(negedge clk_i);
    r            = draw(PayloadWidth);
    in_valid_i   = 1'b1;
    in_dst_x_i   = dst.x;
    in_dst_y_i   = dst.y;
    in_last_i    = last;
    in_payload_i = r[PayloadWidth-1:0];
    // a locked packet keeps the head's direction
    dir      = model_locked ? model_dir : xy_route(dst, xy_id_i);
    tries    = 0;
    accepted = 1'b0;
    while (!accepted && tries < AcceptTimeout) begin
      r           = draw(NumRoutes);
      out_ready_i = r[NumRoutes-1:0];
      if (tries >= ForceReady) begin
        out_ready_i[dir] = 1'b1;
      end
      #1;
      // flit and route held across retries
      check_outputs(name, dir);
      accepted = in_ready_o;
      tries++;
      if (!accepted) begin
        @(negedge clk_i);
      end
    end
    if (!accepted) begin
      errors++;
      $display("timeout, %s was never accepted", name);
      aborted = 1'b1;
    end else begin
      if (!model_locked) begin
        model_dir = dir;
      end
      model_locked = !last;
    end
  endtask

  task automatic send_packet(int unsigned pkt);
    logic [31:0] r;
    int unsigned len;
    xy_id_t      dst;
    r   = draw(2);
    len = r + 1;
    r   = draw(2*CoordWidth);
    dst = r[2*CoordWidth-1:0];
    // a quarter of the heads target the local tile
    r = draw(2);
    if (r == 0) begin
      dst = xy_id_i;
    end
    for (int unsigned i = 0; i < len && !aborted; i++) begin
      if (i > 0) begin
        // body and tail get a fresh dst_id that must be ignored
        r   = draw(2*CoordWidth);
        dst = r[2*CoordWidth-1:0];
      end
      send_flit($sformatf("pkt %0d flit %0d", pkt, i), dst, i == len - 1);
    end
  endtask

  task automatic idle_cycles(int unsigned n);
    logic [31:0] r;
    repeat (n) begin
      @(negedge clk_i);
      r           = draw(2*CoordWidth + NumRoutes);
      in_valid_i  = 1'b0;
      in_dst_x_i  = r[CoordWidth-1:0];
      in_dst_y_i  = r[2*CoordWidth-1:CoordWidth];
      out_ready_i = r[2*CoordWidth+NumRoutes-1:2*CoordWidth];
      #1;
      check_value("idle valid", 32'd0, 32'(out_valid_o));
    end
  endtask

  // reset held low for 4 cycles and the model lock cleared with it
  task automatic apply_reset();
    @(negedge clk_i);
    in_valid_i = 1'b0;
    arst_n_i   = 1'b0;
    repeat (4) @(negedge clk_i);
    arst_n_i     = 1'b1;
    model_locked = 1'b0;
  endtask

  // head locks east and the reset drops the lock
  // so the next flit goes west by its own dst_id
  task automatic reset_mid_packet();
    xy_id_t dst;
    @(negedge clk_i);
    in_valid_i = 1'b0;
    xy_id_i.x  = 3'd3;
    xy_id_i.y  = 3'd3;
    dst.x      = 3'd5;
    dst.y      = 3'd3;
    send_flit("reset head", dst, 1'b0);
    if (!aborted) begin
      apply_reset();
      dst.x = 3'd1;
      send_flit("after reset", dst, 1'b1);
    end
  endtask

  initial begin
    lfsr_q       = 32'h5a7af53c;
    errors       = 0;
    checks       = 0;
    aborted      = 1'b0;
    model_locked = 1'b0;
    model_dir    = Eject;
    arst_n_i     = 1'b1;
    xy_id_i      = '0;
    in_valid_i   = 1'b0;
    in_dst_x_i   = '0;
    in_dst_y_i   = '0;
    in_last_i    = 1'b0;
    in_payload_i = '0;
    out_ready_i  = '0;
    apply_reset();
    for (int p = 0; p < NumPhases && !aborted; p++) begin
      // new local tile only between packets
      @(negedge clk_i);
      in_valid_i = 1'b0;
      rnd        = draw(2*CoordWidth);
      xy_id_i    = rnd[2*CoordWidth-1:0];
      for (int k = 0; k < PktsPerPhase && !aborted; k++) begin
        send_packet(k);
        idle_cycles(draw(2));
      end
    end
    if (!aborted) begin
      reset_mid_packet();
      idle_cycles(2);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog/floo_flit_if.sv
/*
 * floo flit channel
 * valid/ready flit stream, sender drives valid and flit, receiver drives ready
 */

`timescale 1ns/1ps

interface floo_flit_if;
  import floo_pkg::*;

  // handshake, a flit moves on a clock edge with valid and ready high
  logic  valid;
  logic  ready;
  // held stable by the sender until accepted
  flit_t flit;

  // upstream side
  modport sender (output valid, output flit, input ready);

  // downstream side
  modport receiver (input valid, input flit, output ready);

endinterface

// File: verilog/floo_pkg.sv
/*
 * floo package
 * shared mesh parameters, coordinate, header, flit and direction types
 * used by the route selection stage of the mesh router
 */

package floo_pkg;

  // bits per mesh coordinate, one for x and one for y
  localparam int unsigned CoordWidth = 3;

  // payload bits carried by every flit
  localparam int unsigned PayloadWidth = 16;

  // eject plus the four mesh neighbours
  localparam int unsigned NumRoutes = 5;

  // encoded direction width, wide enough for NumRoutes codes
  localparam int unsigned RouteSelWidth = 3;

  // tile coordinate in the mesh
  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } xy_id_t;

  // flit header
  // last marks the tail flit of a packet
  typedef struct packed {
    xy_id_t dst_id;
    logic   last;
  } hdr_t;

  // full flit, header in the upper bits
  typedef struct packed {
    hdr_t                    hdr;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

  // output directions
  // codes double as bit positions in the one-hot route
  //   south and north move along y, west and east along x
  typedef enum logic [RouteSelWidth-1:0] {
    Eject = 3'd0,
    South = 3'd1,
    West  = 3'd2,
    North = 3'd3,
    East  = 3'd4
  } route_dir_e;

endpackage

// File: verilog/floo_route_select.sv
/*
 * floo route select
 * XY route decision for the incoming flit, locked from the head flit
 * to the tail flit so a packet stays on one output
 */

`timescale 1ns/1ps

module floo_route_select (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  floo_flit_if.receiver                  in_ch,
  input  floo_pkg::xy_id_t               xy_id_i,
  output logic [floo_pkg::NumRoutes-1:0] route_sel_o,
  output floo_pkg::route_dir_e           route_sel_id_o
);
  import floo_pkg::*;

  // fresh decision for the flit on the input
  logic [NumRoutes-1:0] route_sel;
  route_dir_e           route_sel_id;

  // lock flag and the route captured with the head flit
  logic                 locked_q;
  logic                 locked_d;
  logic [NumRoutes-1:0] route_sel_q;
  route_dir_e           route_sel_id_q;

  // flit accepted this cycle
  logic                 accept;

  floo_route_xymask u_xymask (
    .dst_id_i    (in_ch.flit.hdr.dst_id),
    .xy_id_i     (xy_id_i),
    .route_sel_o (route_sel)
  );

  // one-hot to direction code
  always_comb begin
    route_sel_id = Eject;
    for (int i = 0; i < NumRoutes; i++) begin
      if (route_sel[i]) begin
        route_sel_id = route_dir_e'(i[RouteSelWidth-1:0]);
      end
    end
  end

  assign accept = in_ch.valid & in_ch.ready;

  // lock after a non-tail flit, release after the tail
  always_comb begin
    locked_d = locked_q;
    if (accept) begin
      locked_d = ~in_ch.flit.hdr.last;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      locked_q <= 1'b0;
    end else begin
      locked_q <= locked_d;
    end
  end

  // track the fresh decision while unlocked
  // the value sampled with the head flit is kept for the packet
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      route_sel_q    <= '0;
      route_sel_id_q <= Eject;
    end else if (!locked_q) begin
      route_sel_q    <= route_sel;
      route_sel_id_q <= route_sel_id;
    end
  end

  // body and tail flits follow the head, whatever their dst_id says
  assign route_sel_o    = locked_q ? route_sel_q : route_sel;
  assign route_sel_id_o = locked_q ? route_sel_id_q : route_sel_id;

endmodule

// File: verilog/floo_route_unit.sv
/*
 * floo route unit
 * top of the route stage, packs the input stream into a flit channel,
 * steers valid to the selected direction and returns that direction's ready
 */

`timescale 1ns/1ps

module floo_route_unit (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  floo_pkg::xy_id_t                  xy_id_i,
  // input flit stream
  input  logic                              in_valid_i,
  input  logic [floo_pkg::CoordWidth-1:0]   in_dst_x_i,
  input  logic [floo_pkg::CoordWidth-1:0]   in_dst_y_i,
  input  logic                              in_last_i,
  input  logic [floo_pkg::PayloadWidth-1:0] in_payload_i,
  output logic                              in_ready_o,
  // output directions, flit broadcast to all of them
  output logic [floo_pkg::NumRoutes-1:0]    out_valid_o,
  input  logic [floo_pkg::NumRoutes-1:0]    out_ready_i,
  output logic [floo_pkg::CoordWidth-1:0]   out_dst_x_o,
  output logic [floo_pkg::CoordWidth-1:0]   out_dst_y_o,
  output logic                              out_last_o,
  output logic [floo_pkg::PayloadWidth-1:0] out_payload_o,
  output floo_pkg::route_dir_e              out_route_id_o
);
  import floo_pkg::*;

  // selected route, one-hot and encoded
  logic [NumRoutes-1:0] route_sel;
  route_dir_e           route_sel_id;

  // ready of the selected direction
  logic                 sel_ready;

  floo_flit_if in_ch ();

  // pack the plain ports into the channel
  assign in_ch.valid                = in_valid_i;
  assign in_ch.flit.hdr.dst_id.x    = in_dst_x_i;
  assign in_ch.flit.hdr.dst_id.y    = in_dst_y_i;
  assign in_ch.flit.hdr.last        = in_last_i;
  assign in_ch.flit.payload         = in_payload_i;

  floo_route_select u_route_select (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .in_ch          (in_ch),
    .xy_id_i        (xy_id_i),
    .route_sel_o    (route_sel),
    .route_sel_id_o (route_sel_id)
  );

  // route is one-hot, so the OR picks exactly the selected ready
  // other directions' ready bits are masked off
  assign sel_ready   = |(out_ready_i & route_sel);
  assign in_ready_o  = sel_ready;
  // the lock logic sees the same handshake as the upstream sender
  assign in_ch.ready = sel_ready;

  // valid only on the chosen direction, zero when the input is idle
  assign out_valid_o = {NumRoutes{in_ch.valid}} & route_sel;

  // flit fields go to every output unchanged
  assign out_dst_x_o    = in_ch.flit.hdr.dst_id.x;
  assign out_dst_y_o    = in_ch.flit.hdr.dst_id.y;
  assign out_last_o     = in_ch.flit.hdr.last;
  assign out_payload_o  = in_ch.flit.payload;
  assign out_route_id_o = route_sel_id;

endmodule

// File: verilog/floo_route_xymask.sv
/*
 * floo XY route mask
 * dimension-ordered routing of a destination against the local tile,
 * x resolved first, then y, eject on a full match, one-hot result
 */

`timescale 1ns/1ps

module floo_route_xymask (
  input  floo_pkg::xy_id_t                dst_id_i,
  input  floo_pkg::xy_id_t                xy_id_i,
  output logic [floo_pkg::NumRoutes-1:0] route_sel_o
);
  import floo_pkg::*;

  // coordinate comparisons
  logic x_lt;
  logic x_gt;
  logic y_lt;
  logic y_gt;

  // destination left of or right of the local tile
  assign x_lt = (dst_id_i.x < xy_id_i.x);
  assign x_gt = (dst_id_i.x > xy_id_i.x);

  // destination below or above the local tile
  assign y_lt = (dst_id_i.y < xy_id_i.y);
  assign y_gt = (dst_id_i.y > xy_id_i.y);

  always_comb begin
    route_sel_o = '0;
    // x first, a packet only turns into y once its column is reached
    if (x_lt) begin
      route_sel_o[West] = 1'b1;
    end else if (x_gt) begin
      route_sel_o[East] = 1'b1;
    end else if (y_lt) begin
      // same column, go down
      route_sel_o[South] = 1'b1;
    end else if (y_gt) begin
      // same column, go up
      route_sel_o[North] = 1'b1;
    end else begin
      // both coordinates match, leave the mesh here
      route_sel_o[Eject] = 1'b1;
    end
  end

endmodule
